// File: include/core_macros.svh
// widths, register count and reset pc of the core
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// instruction and pc
`define INST_WD        32
`define PC_WD          32
`define PC_RESET_VAL   32'h8000_0000

// instruction sram port, one 64-bit word holds two instructions
`define SRAM_ADDR_WD   32
`define SRAM_DATA_WD   64

`define REG_NUM        32 // x0 reads as zero

`endif

// File: rtl/core_pkg.sv
// operation codes and inter-stage bus structs
`include "core_macros.svh"

package core_pkg;

  typedef enum logic [2:0] {
    NOP,
    ADD, // ADD and ADDI
    SUB,
    LUI,
    JAL,
    BEQ
  } alu_op_e;

  typedef struct packed {
    logic              stall;  // decode holds an item, fetch waits
    logic              taken;
    logic [`PC_WD-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [`INST_WD-1:0] inst;
    logic [`PC_WD-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    alu_op_e           op;
    logic [`PC_WD-1:0] pc;
    logic [4:0]        rd;
    logic              we;
    logic [31:0]       src1;
    logic [31:0]       src2;
    logic [31:0]       imm;
  } ds_to_es_t;

  typedef struct packed {
    logic [`PC_WD-1:0] pc;
    logic [4:0]        rd;
    logic              we;
    logic [31:0]       result;
  } es_to_rs_t;

  typedef struct packed {
    logic [`PC_WD-1:0] pc;
    logic [4:0]        rd;
    logic              we;
    logic [31:0]       wdata;
  } retire_t;

endpackage

// File: rtl/fetch_pc.sv
// fetch pc register with sequential step, branch redirect and sram address
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_pc (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_load,
  input  logic                     i_br_taken,
  input  logic [`PC_WD-1:0]        i_br_target,
  output logic [`PC_WD-1:0]        o_pc,
  output logic [`SRAM_ADDR_WD-1:0] o_inst_sram_addr
);

  logic [`PC_WD-1:0] pc;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc <= `PC_RESET_VAL;
    end else if (i_load) begin
      if (i_br_taken) begin
        pc <= i_br_target; // redirect wins over the step
      end else begin
        pc <= pc + `PC_WD'd4;
      end
    end
  end

  assign o_pc = pc;

  // 64-bit sram word, low three bits dropped
  assign o_inst_sram_addr = {pc[`PC_WD-1:3], 3'b000};

endmodule

// File: rtl/fetch_stage.sv
// pre-fetch request, fetch stage with save buffer, redirect cancel and word select
`timescale 1ns/1ps
`include "core_macros.svh"

module fetch_stage (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_ds_allowin,
  input  core_pkg::br_bus_t        i_br_bus,
  output logic                     o_fs_to_ds_valid,
  output core_pkg::fs_to_ds_t      o_fs_to_ds_bus,
  output logic                     o_inst_sram_ren,
  output logic [`SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [`SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                     i_inst_sram_addr_ok,
  input  logic                     i_inst_sram_data_ok
);
  import core_pkg::*;

  logic                fs_start;   // low for the first cycle out of reset
  logic                fs_valid;   // request in flight or word held
  logic                fs_cancel;
  logic                fs_ready_go;
  logic                fs_allowin;
  logic                fs_drop;
  logic                fs_leave;
  logic                req_fire;
  logic [`PC_WD-1:0]   pc;
  logic [`PC_WD-1:0]   req_pc;
  logic                buf_valid;
  logic [`INST_WD-1:0] buf_inst;
  logic [`INST_WD-1:0] sel_inst;

  assign fs_ready_go = i_inst_sram_data_ok || buf_valid;
  assign fs_drop     = fs_cancel || i_br_bus.taken; // wrong-path word
  assign fs_leave    = fs_valid && fs_ready_go && (i_ds_allowin || fs_drop);
  assign fs_allowin  = !fs_valid || fs_leave;

  // no new request in a redirect cycle, the pc is being reloaded
  assign o_inst_sram_ren = fs_start && fs_allowin && !i_br_bus.stall && !i_br_bus.taken;
  assign req_fire        = o_inst_sram_ren && i_inst_sram_addr_ok;

  // pc[2] picks the half of the 64-bit word
  assign sel_inst = req_pc[2] ? i_inst_sram_rdata[`SRAM_DATA_WD-1 -: `INST_WD]
                              : i_inst_sram_rdata[`INST_WD-1:0];

  assign o_fs_to_ds_valid = fs_valid && fs_ready_go && !fs_drop;
  assign o_fs_to_ds_bus   = '{inst: (buf_valid ? buf_inst : sel_inst), pc: req_pc};

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fs_start  <= 1'b0;
      fs_valid  <= 1'b0;
      fs_cancel <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      fs_start <= 1'b1;
      if (fs_allowin) begin
        fs_valid <= req_fire;
      end
      if (fs_valid && !fs_ready_go && i_br_bus.taken) begin
        fs_cancel <= 1'b1; // response still to come, discard it on arrival
      end else if (i_inst_sram_data_ok) begin
        fs_cancel <= 1'b0;
      end
      if (i_inst_sram_data_ok && !fs_leave) begin
        buf_valid <= 1'b1; // decode busy
      end else if (fs_leave) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_fire) begin
      req_pc <= pc;
    end
    if (i_inst_sram_data_ok && !fs_leave) begin
      buf_inst <= sel_inst;
    end
  end

  fetch_pc u_pc (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_load           (req_fire || i_br_bus.taken),
    .i_br_taken       (i_br_bus.taken),
    .i_br_target      (i_br_bus.target),
    .o_pc             (pc),
    .o_inst_sram_addr (o_inst_sram_addr)
  );

  // one request at most, so a response needs an open slot without a saved word
  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_inst_sram_data_ok |-> (fs_valid && !buf_valid));

endmodule

// File: rtl/decode_stage.sv
// decode stage with register file, operand bypass, interlock and branch resolve
`timescale 1ns/1ps
`include "core_macros.svh"

module decode_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_fs_to_ds_valid,
  input  core_pkg::fs_to_ds_t i_fs_to_ds_bus,
  output logic                o_ds_allowin,
  output core_pkg::br_bus_t   o_br_bus,
  input  logic                i_es_allowin,
  input  logic [4:0]          i_es_rd,
  input  logic                i_es_wr,
  output logic                o_ds_to_es_valid,
  output core_pkg::ds_to_es_t o_ds_to_es_bus,
  input  logic                i_rf_we,
  input  logic [4:0]          i_rf_waddr,
  input  logic [31:0]         i_rf_wdata
);
  import core_pkg::*;

  logic        ds_valid;
  logic        ds_ready_go;
  fs_to_ds_t   ds_item;
  logic [31:0] rf [`REG_NUM];
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic        is_addi, is_add, is_sub, is_lui, is_beq, is_jal;
  logic        use_rs1, use_rs2, wr_rd, hazard, br_taken;
  logic [31:0] imm;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  alu_op_e     op;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = ds_item.inst;

  assign is_addi = (opcode == 7'b0010011) && (funct3 == 3'b000);
  assign is_add  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign is_sub  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign is_lui  = (opcode == 7'b0110111);
  assign is_beq  = (opcode == 7'b1100011) && (funct3 == 3'b000);
  assign is_jal  = (opcode == 7'b1101111);

  always_comb begin
    op  = NOP; // unknown encodings retire as no-ops
    imm = '0;
    if (is_addi) begin
      op  = ADD;
      imm = {{20{ds_item.inst[31]}}, ds_item.inst[31:20]};
    end else if (is_add) begin
      op = ADD;
    end else if (is_sub) begin
      op = SUB;
    end else if (is_lui) begin
      op  = LUI;
      imm = {ds_item.inst[31:12], 12'b0};
    end else if (is_beq) begin
      op  = BEQ;
      imm = {{20{ds_item.inst[31]}}, ds_item.inst[7], ds_item.inst[30:25],
             ds_item.inst[11:8], 1'b0};
    end else if (is_jal) begin
      op  = JAL;
      imm = {{12{ds_item.inst[31]}}, ds_item.inst[19:12], ds_item.inst[20],
             ds_item.inst[30:21], 1'b0};
    end
  end

  assign use_rs1 = is_addi || is_add || is_sub || is_beq;
  assign use_rs2 = is_add || is_sub || is_beq;
  assign wr_rd   = (is_addi || is_add || is_sub || is_lui || is_jal) && (rd != 5'd0);

  // result stage write seen in the same cycle
  assign rs1_val = (rs1 == 5'd0) ? '0 :
                   (i_rf_we && i_rf_waddr == rs1) ? i_rf_wdata : rf[rs1];
  assign rs2_val = (rs2 == 5'd0) ? '0 :
                   (i_rf_we && i_rf_waddr == rs2) ? i_rf_wdata : rf[rs2];

  // execute has no forwarding path
  assign hazard = i_es_wr && ((use_rs1 && rs1 == i_es_rd) || (use_rs2 && rs2 == i_es_rd));

  assign ds_ready_go      = !hazard;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  assign br_taken = o_ds_to_es_valid && i_es_allowin && (is_jal || (is_beq && rs1_val == rs2_val));
  assign o_br_bus = '{stall: (ds_valid && !ds_ready_go), taken: br_taken,
                      target: ds_item.pc + imm};

  // ADDI carries its immediate as the second operand
  assign o_ds_to_es_bus = '{op: op, pc: ds_item.pc, rd: rd, we: wr_rd, src1: rs1_val,
                            src2: (is_addi ? imm : rs2_val), imm: imm};

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_item <= i_fs_to_ds_bus;
    end
    if (i_rf_we) begin
      rf[i_rf_waddr] <= i_rf_wdata;
    end
  end

  // the writer in execute has left by the next cycle
  assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (ds_valid && !ds_ready_go) |=> ds_ready_go);

  assert property (@(posedge i_clk) disable iff (!i_arst_n) i_rf_we |-> (i_rf_waddr != 5'd0));

endmodule

// File: rtl/execute_stage.sv
// execute stage register and alu
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_ds_to_es_valid,
  input  core_pkg::ds_to_es_t i_ds_to_es_bus,
  output logic                o_es_allowin,
  output logic [4:0]          o_es_rd,
  output logic                o_es_wr,
  input  logic                i_rs_allowin,
  output logic                o_es_to_rs_valid,
  output core_pkg::es_to_rs_t o_es_to_rs_bus
);
  import core_pkg::*;

  logic        es_valid;
  ds_to_es_t   es_item;
  logic [31:0] result;

  assign o_es_allowin = !es_valid || i_rs_allowin; // single-cycle stage

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      es_valid <= 1'b0;
    end else if (o_es_allowin) begin
      es_valid <= i_ds_to_es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid && o_es_allowin) begin
      es_item <= i_ds_to_es_bus;
    end
  end

  always_comb begin
    case (es_item.op)
      ADD:     result = es_item.src1 + es_item.src2;
      SUB:     result = es_item.src1 - es_item.src2;
      LUI:     result = es_item.imm;
      JAL:     result = es_item.pc + `PC_WD'd4; // link address
      default: result = '0; // BEQ and NOP write nothing
    endcase
  end

  // pending write target for the decode interlock
  assign o_es_rd = es_item.rd;
  assign o_es_wr = es_valid && es_item.we;

  assign o_es_to_rs_valid = es_valid;
  assign o_es_to_rs_bus   = '{pc: es_item.pc, rd: es_item.rd, we: es_item.we, result: result};

endmodule

// File: rtl/result_stage.sv
// result stage register, register file write and retire report
`timescale 1ns/1ps

module result_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_es_to_rs_valid,
  input  core_pkg::es_to_rs_t i_es_to_rs_bus,
  output logic                o_rs_allowin,
  output logic                o_rf_we,
  output logic [4:0]          o_rf_waddr,
  output logic [31:0]         o_rf_wdata,
  output logic                o_retire_valid,
  output core_pkg::retire_t   o_retire
);
  import core_pkg::*;

  logic      rs_valid;
  es_to_rs_t rs_item;

  assign o_rs_allowin = 1'b1; // retire is never back-pressured

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rs_valid <= 1'b0;
    end else begin
      rs_valid <= i_es_to_rs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_rs_valid) begin
      rs_item <= i_es_to_rs_bus;
    end
  end

  assign o_rf_we    = rs_valid && rs_item.we;
  assign o_rf_waddr = rs_item.rd;
  assign o_rf_wdata = rs_item.result;

  assign o_retire_valid = rs_valid; // one cycle per item
  assign o_retire       = '{pc: rs_item.pc, rd: rs_item.rd, we: rs_item.we, wdata: rs_item.result};

  assert property (@(posedge i_clk) disable iff (!i_arst_n) o_rf_we |-> (o_rf_waddr != 5'd0));

endmodule

// File: rtl/core_top.sv
// core top level: fetch, decode, execute and result stages
`timescale 1ns/1ps
`include "core_macros.svh"

module core_top (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  output logic                     o_inst_sram_ren,
  output logic [`SRAM_ADDR_WD-1:0] o_inst_sram_addr,
  input  logic [`SRAM_DATA_WD-1:0] i_inst_sram_rdata,
  input  logic                     i_inst_sram_addr_ok,
  input  logic                     i_inst_sram_data_ok,
  output logic                     o_retire_valid,
  output core_pkg::retire_t        o_retire
);
  import core_pkg::*;

  logic        fs_to_ds_valid, ds_allowin, ds_to_es_valid, es_allowin;
  logic        es_to_rs_valid, rs_allowin, es_wr, rf_we;
  logic [4:0]  es_rd, rf_waddr;
  logic [31:0] rf_wdata;
  fs_to_ds_t   fs_to_ds_bus;
  ds_to_es_t   ds_to_es_bus;
  es_to_rs_t   es_to_rs_bus;
  br_bus_t     br_bus;

  fetch_stage u_fs (
    .i_clk (i_clk), .i_arst_n (i_arst_n), .i_ds_allowin (ds_allowin), .i_br_bus (br_bus),
    .o_fs_to_ds_valid (fs_to_ds_valid), .o_fs_to_ds_bus (fs_to_ds_bus),
    .o_inst_sram_ren (o_inst_sram_ren), .o_inst_sram_addr (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata), .i_inst_sram_addr_ok (i_inst_sram_addr_ok),
    .i_inst_sram_data_ok (i_inst_sram_data_ok)
  );

  decode_stage u_ds (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid), .i_fs_to_ds_bus (fs_to_ds_bus),
    .o_ds_allowin (ds_allowin), .o_br_bus (br_bus), .i_es_allowin (es_allowin),
    .i_es_rd (es_rd), .i_es_wr (es_wr),
    .o_ds_to_es_valid (ds_to_es_valid), .o_ds_to_es_bus (ds_to_es_bus),
    .i_rf_we (rf_we), .i_rf_waddr (rf_waddr), .i_rf_wdata (rf_wdata)
  );

  execute_stage u_es (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_ds_to_es_valid (ds_to_es_valid), .i_ds_to_es_bus (ds_to_es_bus),
    .o_es_allowin (es_allowin), .o_es_rd (es_rd), .o_es_wr (es_wr),
    .i_rs_allowin (rs_allowin),
    .o_es_to_rs_valid (es_to_rs_valid), .o_es_to_rs_bus (es_to_rs_bus)
  );

  result_stage u_rs (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_es_to_rs_valid (es_to_rs_valid), .i_es_to_rs_bus (es_to_rs_bus),
    .o_rs_allowin (rs_allowin),
    .o_rf_we (rf_we), .o_rf_waddr (rf_waddr), .o_rf_wdata (rf_wdata),
    .o_retire_valid (o_retire_valid), .o_retire (o_retire)
  );

endmodule

// File: bench/tb_core.sv
// core testbench with clock, reset, instruction sram model, reference model and directed tests
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_core;
  import core_pkg::*;

  localparam int I_ADDI = 0;
  localparam int I_ADD = 1;
  localparam int I_SUB = 2;
  localparam int I_LUI = 3;
  localparam int I_BEQ = 4;
  localparam int I_JAL = 5;
  localparam int I_OTHER = 6; // OR, not supported by the core
  localparam int PROG_LEN = 64;
  localparam logic [31:0] SELF_LOOP = 32'h0000_006f; // jal x0, 0

  logic                     clk;
  logic                     arst_n;
  logic                     sram_ren;
  logic [`SRAM_ADDR_WD-1:0] sram_addr;
  logic [`SRAM_DATA_WD-1:0] sram_rdata;
  logic                     sram_addr_ok;
  logic                     sram_data_ok;
  logic                     retire_valid;
  retire_t                  retire;

  logic [31:0] prog [PROG_LEN];
  int          p_op [PROG_LEN];
  logic [4:0]  p_rd [PROG_LEN];
  logic [4:0]  p_rs1 [PROG_LEN];
  logic [4:0]  p_rs2 [PROG_LEN];
  logic [31:0] p_imm [PROG_LEN];
  retire_t     exp_q [$];
  logic [31:0] end_pc;     // pc of the closing self jump

  string       test_name;
  int          errors;
  int          checks;
  integer      seed;
  logic        rand_stall;
  logic        fetched;    // a response has come back since reset
  logic        pending;
  logic [31:0] pend_addr;
  int          wait_cnt;
  logic        reset_s;
  logic        accept_s;
  logic        resp_s;
  logic [31:0] addr_s;

  core_top dut_i (
    .i_clk               (clk),
    .i_arst_n            (arst_n),
    .o_inst_sram_ren     (sram_ren),
    .o_inst_sram_addr    (sram_addr),
    .i_inst_sram_rdata   (sram_rdata),
    .i_inst_sram_addr_ok (sram_addr_ok),
    .i_inst_sram_data_ok (sram_data_ok),
    .o_retire_valid      (retire_valid),
    .o_retire            (retire)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] inst_at(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `PC_RESET_VAL;
    return (off < PROG_LEN * 4) ? prog[off[31:2]] : SELF_LOOP;
  endfunction

  // instruction sram, one request in flight, answer 1 to 3 cycles after acceptance
  always begin
    @(negedge clk);
    reset_s  = !arst_n;
    accept_s = sram_ren && sram_addr_ok;
    resp_s   = sram_data_ok;
    addr_s   = sram_addr;
    assert (!(retire_valid && !fetched)) else begin
      errors++;
      $display("%s: an instruction retired before any fetch returned", test_name);
    end
    @(posedge clk);
    #1;
    if (resp_s) begin
      pending = 1'b0;
      fetched = 1'b1;
    end
    if (accept_s) begin
      pending   = 1'b1;
      pend_addr = addr_s;
      wait_cnt  = $unsigned($random(seed)) % 3;
    end else if (wait_cnt > 0) begin
      wait_cnt--;
    end
    if (reset_s) begin
      pending = 1'b0;
      fetched = 1'b0;
    end
    sram_data_ok = pending && (wait_cnt == 0);
    sram_rdata   = {inst_at(pend_addr + 4), inst_at(pend_addr)};
    sram_addr_ok = rand_stall ? ($random(seed) % 3 != 0) : 1'b1;
  end

  task automatic place_inst(input int idx, input int op, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [31:0] imm);
    p_op[idx]  = op;
    p_rd[idx]  = rd;
    p_rs1[idx] = rs1;
    p_rs2[idx] = rs2;
    p_imm[idx] = imm;
    case (op)
      I_ADDI:  prog[idx] = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      I_ADD:   prog[idx] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      I_SUB:   prog[idx] = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      I_LUI:   prog[idx] = {imm[31:12], rd, 7'b0110111};
      I_BEQ:   prog[idx] = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
      I_OTHER: prog[idx] = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      default: prog[idx] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endcase
  endtask

  task automatic clear_prog;
    for (int i = 0; i < PROG_LEN; i++) begin
      place_inst(i, I_JAL, 0, 0, 0, 0);
    end
  endtask

  // ISA-level run of the program, stops at the first jump to itself
  task automatic run_model;
    logic [31:0] rf [32];
    logic [31:0] pc;
    int          idx;
    retire_t     r;
    pc = `PC_RESET_VAL;
    exp_q.delete();
    foreach (rf[i]) begin
      rf[i] = '0;
    end
    for (int step = 0; step < 100; step++) begin
      idx = (pc - `PC_RESET_VAL) >> 2;
      if (idx >= PROG_LEN || (p_op[idx] == I_JAL && p_imm[idx] == 0)) begin
        break;
      end
      r = '{pc: pc, rd: p_rd[idx], we: 1'b0, wdata: '0};
      case (p_op[idx])
        I_ADDI:  r.wdata = rf[p_rs1[idx]] + p_imm[idx];
        I_ADD:   r.wdata = rf[p_rs1[idx]] + rf[p_rs2[idx]];
        I_SUB:   r.wdata = rf[p_rs1[idx]] - rf[p_rs2[idx]];
        I_LUI:   r.wdata = p_imm[idx];
        I_JAL:   r.wdata = pc + 4;
        default: r.wdata = '0;
      endcase
      r.we = (p_op[idx] <= I_LUI || p_op[idx] == I_JAL) && (p_rd[idx] != 5'd0);
      if (p_op[idx] == I_JAL || (p_op[idx] == I_BEQ && rf[p_rs1[idx]] == rf[p_rs2[idx]])) begin
        pc = pc + p_imm[idx];
      end else begin
        pc = pc + 4;
      end
      if (r.we) begin
        rf[r.rd] = r.wdata;
      end
      exp_q.push_back(r);
    end
    end_pc = pc;
  endtask

  task automatic reset_core;
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    repeat (15) @(posedge clk);
    @(negedge clk);
    assert (!sram_ren && !retire_valid) else begin
      errors++;
      $display("%s: fetch request or retire active during reset", test_name);
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic wait_retire(output logic seen, output retire_t got);
    seen = 1'b0;
    got  = '0;
    for (int n = 0; n < 200 && !seen; n++) begin
      @(negedge clk);
      if (retire_valid) begin
        seen = 1'b1;
        got  = retire;
      end
    end
    if (!seen) begin
      errors++;
      $display("%s: timed out waiting for a retired instruction", test_name);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic run_test(input string name);
    retire_t got;
    logic    seen;
    test_name = name;
    seen      = 1'b1;
    run_model;
    reset_core;
    foreach (exp_q[i]) begin
      wait_retire(seen, got);
      if (!seen) begin
        break;
      end
      check_value("pc", exp_q[i].pc, got.pc);
      check_value("we", exp_q[i].we, got.we);
      if (exp_q[i].we) begin // rd and wdata only mean something on a write
        check_value("rd", exp_q[i].rd, got.rd);
        check_value("wdata", exp_q[i].wdata, got.wdata);
      end
    end
    if (seen) begin
      wait_retire(seen, got); // nothing extra before the closing self jump
      if (seen) begin
        check_value("end pc", end_pc, got.pc);
      end
    end
  endtask

  task automatic test_arith;
    clear_prog;
    place_inst(0, I_ADDI, 1, 0, 0, 5);
    place_inst(1, I_ADDI, 2, 0, 0, -3);
    place_inst(2, I_LUI, 3, 0, 0, 32'h1234_5000);
    place_inst(3, I_ADDI, 4, 0, 0, 100);
    place_inst(4, I_ADD, 5, 1, 2, 0);
    place_inst(5, I_SUB, 6, 4, 1, 0);
    place_inst(6, I_ADDI, 7, 3, 0, 32'h678);
    run_test("arith");
  endtask

  task automatic test_dependent;
    clear_prog;
    place_inst(0, I_ADDI, 1, 0, 0, 1);
    place_inst(1, I_ADD, 2, 1, 1, 0);
    place_inst(2, I_ADD, 3, 2, 1, 0);
    place_inst(3, I_SUB, 4, 3, 2, 0);
    place_inst(4, I_ADDI, 4, 4, 0, -7);
    place_inst(5, I_ADD, 5, 4, 4, 0);
    run_test("dependent");
  endtask

  task automatic load_branch_prog;
    clear_prog;
    place_inst(0, I_ADDI, 1, 0, 0, 7);
    place_inst(1, I_ADDI, 2, 0, 0, 7);
    place_inst(2, I_ADDI, 3, 0, 0, 1);
    place_inst(3, I_BEQ, 0, 1, 2, 12); // taken
    place_inst(4, I_ADDI, 4, 0, 0, 11);
    place_inst(5, I_ADDI, 4, 0, 0, 22);
    place_inst(6, I_BEQ, 0, 1, 3, 8);  // falls through
    place_inst(7, I_JAL, 5, 0, 0, 12);
    place_inst(8, I_ADDI, 6, 0, 0, 33);
    place_inst(9, I_ADDI, 6, 0, 0, 44);
    place_inst(10, I_ADD, 7, 5, 1, 0);
  endtask

  task automatic test_branch;
    load_branch_prog;
    run_test("branch");
  endtask

  task automatic test_branch_dependent;
    clear_prog;
    place_inst(0, I_ADDI, 1, 0, 0, 3);
    place_inst(1, I_ADDI, 2, 0, 0, 3);
    place_inst(2, I_BEQ, 0, 1, 2, 8);
    place_inst(3, I_ADDI, 3, 0, 0, 1);
    place_inst(4, I_ADDI, 1, 1, 0, 1);
    place_inst(5, I_BEQ, 0, 1, 2, 8);
    place_inst(6, I_ADDI, 3, 0, 0, 9);
    run_test("branch_dependent");
  endtask

  task automatic test_random_stall;
    rand_stall = 1'b1;
    clear_prog;
    place_inst(0, I_ADDI, 1, 0, 0, 0);
    place_inst(1, I_ADDI, 2, 0, 0, 4);
    place_inst(2, I_ADDI, 3, 0, 0, 0);
    place_inst(3, I_ADDI, 1, 1, 0, 1);   // loop body
    place_inst(4, I_ADD, 3, 3, 1, 0);
    place_inst(5, I_BEQ, 0, 1, 2, 8);
    place_inst(6, I_JAL, 0, 0, 0, -12);
    place_inst(7, I_SUB, 4, 3, 2, 0);
    run_test("random_stall_loop");
    load_branch_prog;
    run_test("random_stall_branch");
    rand_stall = 1'b0;
  endtask

  task automatic test_x0_write;
    clear_prog;
    place_inst(0, I_ADDI, 0, 0, 0, 55);
    place_inst(1, I_LUI, 0, 0, 0, 32'h7000_0000);
    place_inst(2, I_ADD, 1, 0, 0, 0);
    place_inst(3, I_ADDI, 2, 1, 0, 1);
    place_inst(4, I_ADDI, 3, 0, 0, 40);
    place_inst(5, I_OTHER, 3, 1, 2, 0); // retires without a write
    place_inst(6, I_ADD, 4, 3, 2, 0);
    run_test("x0_write");
  endtask

  initial begin
    arst_n       = 1'b0;
    sram_rdata   = '0;
    sram_addr_ok = 1'b1;
    sram_data_ok = 1'b0;
    pending      = 1'b0;
    pend_addr    = '0;
    wait_cnt     = 0;
    fetched      = 1'b0;
    rand_stall   = 1'b0;
    seed         = 78;
    errors       = 0;
    checks       = 0;
    test_name    = "reset";
    test_arith;
    test_dependent;
    test_branch;
    test_branch_dependent;
    test_random_stall;
    test_x0_write;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
rtl/core_pkg.sv
rtl/fetch_pc.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
bench/tb_core.sv

// File: Bender.yml
package:
  name: rv32_pipe_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/core_pkg.sv
      - rtl/fetch_pc.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/result_stage.sv
      - rtl/core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_core.sv
